//--- all.f
verilog/avmm_pkg.sv
verilog/avmm_fifo.sv
verilog/avmm_buffer_shim.sv
verilog/avmm_arbiter.sv
verilog/avmm_sram.sv
verilog/avmm_mem_top.sv
bench/avmm_mem_sva.sv
bench/tb_avmm_mem.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_avmm_mem
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Something failed" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	elif ! grep -q "Everything OK" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_avmm_mem.sv
// Two-port memory subsystem testbench
`timescale 1ns/10ps

module tb_avmm_mem;

    import avmm_pkg::*;

    // Roughly 200 requests are issued, each given up to 20 cycles
    localparam int TIMEOUT_CYCLES = 20 * 200;
    localparam int STREAM_LEN = 40;

    // What one response should look like
    typedef struct packed {
        logic is_read;
        logic [DATA_W-1:0] data;
        logic [1:0] code;
    } exp_t;

    logic mem_master;
    logic rst;
    avmm_req_t req [2];
    logic [1:0] waitreq;
    avmm_rsp_t rsp [2];

    // Reference copy of the word memory and the per-port response queues
    logic [DATA_W-1:0] model [MEM_WORDS];
    exp_t exp_q [2][$];
    logic [DATA_W-1:0] stream_data [2][STREAM_LEN];
    logic [1:0] stalled;
    integer seed;
    int cycles;

    avmm_mem_top u_dut
    (
        .mem_master(mem_master),
        .rst(rst),
        .req0(req[0]),
        .req1(req[1]),
        .waitrequest0(waitreq[0]),
        .waitrequest1(waitreq[1]),
        .rsp0(rsp[0]),
        .rsp1(rsp[1])
    );

    always #5 mem_master = ~mem_master;

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    function automatic avmm_req_t write_cmd(input int addr, input logic [DATA_W-1:0] data,
                                            input logic [BE_W-1:0] be);
        avmm_req_t r;
        r = '0;
        r.write = 1'b1;
        r.address = ADDR_W'(addr);
        r.writedata = data;
        r.byteenable = be;
        return r;
    endfunction

    function automatic avmm_req_t read_cmd(input int addr);
        avmm_req_t r;
        r = '0;
        r.read = 1'b1;
        r.address = ADDR_W'(addr);
        r.byteenable = '1;
        return r;
    endfunction

    // Applies an accepted command to the model and queues its expected response.
    // Out-of-range commands leave the model alone and expect SLVERR with zero data
    task automatic predict(input logic port, input avmm_req_t r);
        exp_t e;
        logic ok;
        ok = (int'(r.address) < MEM_WORDS);
        e.is_read = r.read;
        e.code = ok ? RSP_OKAY : RSP_SLVERR;
        e.data = '0;
        if (r.write && ok)
        begin
            for (int b = 0; b < BE_W; b++)
            begin
                if (r.byteenable[b])
                begin
                    model[r.address[MEM_AW-1:0]][b*8 +: 8] = r.writedata[b*8 +: 8];
                end
            end
        end
        if (r.read && ok)
        begin
            e.data = model[r.address[MEM_AW-1:0]];
        end
        exp_q[port].push_back(e);
    endtask

    // Waitrequest is registered, so its value at the falling edge decides the next rising edge
    task automatic send(input logic port, input avmm_req_t r);
        @(negedge mem_master);
        req[port] = r;
        while (waitreq[port])
        begin
            stalled[port] = 1'b1;
            @(negedge mem_master);
        end
        predict(port, r);
    endtask

    task automatic release_port(input logic port);
        @(negedge mem_master);
        req[port] = '0;
    endtask

    task automatic wait_idle();
        while (exp_q[0].size() != 0 || exp_q[1].size() != 0)
        begin
            @(posedge mem_master);
        end
    endtask

    task automatic single_op(input logic port, input avmm_req_t r);
        send(port, r);
        release_port(port);
        wait_idle();
    endtask

    // Compares a valid response with the oldest outstanding command of that port
    task automatic check_rsp(input logic port);
        exp_t e;
        if (rsp[port].readdatavalid || rsp[port].writeresponsevalid)
        begin
            assert (exp_q[port].size() != 0)
            else
            begin
                $display("Port %0d returned a response with no command outstanding", port);
                abort_run();
            end
            e = exp_q[port].pop_front();
            assert (rsp[port].readdatavalid == e.is_read &&
                    rsp[port].writeresponsevalid == !e.is_read)
            else
            begin
                $display("Port %0d returned a response of the wrong kind", port);
                abort_run();
            end
            if (e.is_read)
            begin
                assert (rsp[port].readdata == e.data)
                else
                begin
                    $display("Mismatch rsp%0d.readdata: got 0x%h, expected 0x%h",
                             port, rsp[port].readdata, e.data);
                    abort_run();
                end
                assert (rsp[port].response == e.code)
                else
                begin
                    $display("Mismatch rsp%0d.response: got 0x%h, expected 0x%h",
                             port, rsp[port].response, e.code);
                    abort_run();
                end
            end
            else
            begin
                assert (rsp[port].writeresponse == e.code)
                else
                begin
                    $display("Mismatch rsp%0d.writeresponse: got 0x%h, expected 0x%h",
                             port, rsp[port].writeresponse, e.code);
                    abort_run();
                end
            end
        end
    endtask

    // Responses are registered in the DUT and stable at the falling edge
    always @(negedge mem_master)
    begin
        if (!rst)
        begin
            check_rsp(1'b0);
            check_rsp(1'b1);
        end
    end

    always @(posedge mem_master)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    // Called at the falling edge where reset drops
    task automatic reset_state();
        assert (waitreq == 2'b11)
        else
        begin
            $display("Mismatch waitrequest: got 0x%h, expected 0x3", waitreq);
            abort_run();
        end
        @(negedge mem_master);
        assert (waitreq == 2'b00)
        else
        begin
            $display("Mismatch waitrequest: got 0x%h, expected 0x0", waitreq);
            abort_run();
        end
        repeat (3)
        begin
            assert (!rsp[0].readdatavalid && !rsp[0].writeresponsevalid &&
                    !rsp[1].readdatavalid && !rsp[1].writeresponsevalid)
            else
            begin
                $display("A response appeared before any request was issued");
                abort_run();
            end
            @(negedge mem_master);
        end
    endtask

    task automatic write_read_pairs();
        for (int p = 0; p < 2; p++)
        begin
            for (int i = 0; i < 4; i++)
            begin
                single_op(1'(p), write_cmd(16 * p + i, $random(seed), 4'hf));
                single_op(1'(p), read_cmd(16 * p + i));
            end
        end
    endtask

    task automatic byte_enable_merge();
        for (int p = 0; p < 2; p++)
        begin
            single_op(1'(p), write_cmd(32 + p, $random(seed), 4'hf));
            single_op(1'(p), write_cmd(32 + p, $random(seed), 4'b0101));
            single_op(1'(p), write_cmd(32 + p, $random(seed), 4'b1000));
            single_op(1'(p), read_cmd(32 + p));
        end
    endtask

    // The out-of-range write aliases the low address bits of a known word
    task automatic out_of_range_access();
        for (int p = 0; p < 2; p++)
        begin
            single_op(1'(p), write_cmd(48 + p, $random(seed), 4'hf));
            single_op(1'(p), read_cmd(p == 0 ? MEM_WORDS : 1023));
            single_op(1'(p), write_cmd(MEM_WORDS + 48 + p, $random(seed), 4'hf));
            single_op(1'(p), read_cmd(48 + p));
        end
    endtask

    task automatic stream_port(input logic port, input int base);
        for (int i = 0; i < STREAM_LEN; i++)
        begin
            send(port, write_cmd(base + i, stream_data[port][i], 4'hf));
        end
        for (int i = 0; i < STREAM_LEN; i++)
        begin
            send(port, read_cmd(base + i));
        end
        release_port(port);
    endtask

    // Both ports stream without waiting for responses
    task automatic dual_port_stream();
        for (int p = 0; p < 2; p++)
        begin
            for (int i = 0; i < STREAM_LEN; i++)
            begin
                stream_data[p][i] = $random(seed);
            end
        end
        stalled = 2'b00;
        fork
            stream_port(1'b0, 100);
            stream_port(1'b1, 150);
        join
        wait_idle();
        assert (stalled == 2'b11)
        else
        begin
            $display("Waitrequest never rose on both ports during the stream test");
            abort_run();
        end
    endtask

    initial
    begin
        seed = 37036;
        cycles = 0;
        mem_master = 1'b0;
        rst = 1'b1;
        req[0] = '0;
        req[1] = '0;
        stalled = 2'b00;
        repeat (4) @(negedge mem_master);
        rst = 1'b0;
        reset_state();
        write_read_pairs();
        byte_enable_merge();
        out_of_range_access();
        dual_port_stream();
        wait_idle();
        $display("Everything OK");
        $finish;
    end

endmodule

//--- bench/avmm_mem_sva.sv
// Arbiter protocol assertions
`timescale 1ns/10ps

module avmm_arbiter_sva
(
    input  logic mem_master,
    input  logic rst,
    input  logic grant0,
    input  logic grant1,
    input  logic order_push,
    input  logic [avmm_pkg::ORDER_SPACE_W-1:0] order_space,
    input  logic order_not_empty,
    input  logic rsp_valid
);

    // At most one port wins in any cycle
    grant_onehot: assert property (@(posedge mem_master) disable iff (rst)
        !(grant0 && grant1))
        else $error("Both ports were granted in the same cycle");

    // Every grant needs a free slot to record its port
    order_no_overflow: assert property (@(posedge mem_master) disable iff (rst)
        !(order_push && (order_space == '0)))
        else $error("Order FIFO pushed while full");

    // Each memory response must belong to a recorded command
    rsp_has_owner: assert property (@(posedge mem_master) disable iff (rst)
        !(rsp_valid && !order_not_empty))
        else $error("Memory response arrived with the order FIFO empty");

endmodule

bind avmm_arbiter avmm_arbiter_sva u_arbiter_sva
(
    .mem_master(mem_master),
    .rst(rst),
    .grant0(grant0),
    .grant1(grant1),
    .order_push(order_push),
    .order_space(order_space),
    .order_not_empty(order_not_empty),
    .rsp_valid(rsp_valid)
);

//--- verilog/avmm_mem_top.sv
// Two-port Avalon memory subsystem
`timescale 1ns/10ps

module avmm_mem_top
(
    input  logic mem_master,
    input  logic rst,
    input  avmm_pkg::avmm_req_t req0,
    input  avmm_pkg::avmm_req_t req1,
    output logic waitrequest0,
    output logic waitrequest1,
    output avmm_pkg::avmm_rsp_t rsp0,
    output avmm_pkg::avmm_rsp_t rsp1
);

    import avmm_pkg::*;

    // Shim to arbiter
    avmm_req_t cmd0;
    avmm_req_t cmd1;
    logic cmd_valid0;
    logic cmd_valid1;
    logic grant0;
    logic grant1;

    // Arbiter to memory and back
    avmm_req_t mem_req;
    avmm_rsp_t mem_rsp;
    avmm_rsp_t side_rsp0;
    avmm_rsp_t side_rsp1;

    avmm_buffer_shim u_shim0
    (
        .mem_master(mem_master),
        .rst(rst),
        .req(req0),
        .waitrequest(waitrequest0),
        .rsp(rsp0),
        .cmd(cmd0),
        .cmd_valid(cmd_valid0),
        .grant(grant0),
        .mem_side_rsp(side_rsp0)
    );

    avmm_buffer_shim u_shim1
    (
        .mem_master(mem_master),
        .rst(rst),
        .req(req1),
        .waitrequest(waitrequest1),
        .rsp(rsp1),
        .cmd(cmd1),
        .cmd_valid(cmd_valid1),
        .grant(grant1),
        .mem_side_rsp(side_rsp1)
    );

    avmm_arbiter u_arbiter
    (
        .mem_master(mem_master),
        .rst(rst),
        .cmd0(cmd0),
        .cmd1(cmd1),
        .cmd_valid0(cmd_valid0),
        .cmd_valid1(cmd_valid1),
        .grant0(grant0),
        .grant1(grant1),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp),
        .rsp0(side_rsp0),
        .rsp1(side_rsp1)
    );

    avmm_sram u_sram
    (
        .mem_master(mem_master),
        .rst(rst),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp)
    );

endmodule

//--- verilog/avmm_sram.sv
// Shared on-chip word memory
`timescale 1ns/10ps

module avmm_sram
(
    input  logic mem_master,
    input  logic rst,
    input  avmm_pkg::avmm_req_t mem_req,
    output avmm_pkg::avmm_rsp_t mem_rsp
);

    import avmm_pkg::*;

    logic [DATA_W-1:0] mem [MEM_WORDS];

    logic in_range;
    logic [MEM_AW-1:0] word_idx;

    // First pipeline stage
    logic s1_read;
    logic s1_write;
    logic s1_err;
    logic [DATA_W-1:0] s1_rdata;

    assign in_range = (mem_req.address < ADDR_W'(MEM_WORDS));
    assign word_idx = mem_req.address[MEM_AW-1:0];

    // Byte-enabled write, skipped entirely for out-of-range addresses
    always_ff @(posedge mem_master)
    begin
        if (mem_req.write && in_range)
        begin
            for (int b = 0; b < BE_W; b++)
            begin
                if (mem_req.byteenable[b])
                begin
                    mem[word_idx][b*8 +: 8] <= mem_req.writedata[b*8 +: 8];
                end
            end
        end
    end

    // Stage 1 reads the array and records the command kind and range status
    always_ff @(posedge mem_master)
    begin
        s1_err <= !in_range;
        s1_rdata <= in_range ? mem[word_idx] : '0;
        if (rst)
        begin
            s1_read <= 1'b0;
            s1_write <= 1'b0;
        end
        else
        begin
            s1_read <= mem_req.read;
            s1_write <= mem_req.write;
        end
    end

    // Stage 2 forms the response, two cycles after the command
    always_ff @(posedge mem_master)
    begin
        mem_rsp.readdata <= s1_rdata;
        mem_rsp.response <= s1_err ? RSP_SLVERR : RSP_OKAY;
        mem_rsp.writeresponse <= s1_err ? RSP_SLVERR : RSP_OKAY;
        if (rst)
        begin
            mem_rsp.readdatavalid <= 1'b0;
            mem_rsp.writeresponsevalid <= 1'b0;
        end
        else
        begin
            mem_rsp.readdatavalid <= s1_read;
            mem_rsp.writeresponsevalid <= s1_write;
        end
    end

endmodule

//--- verilog/avmm_arbiter.sv
// Round-robin arbiter with response routing
`timescale 1ns/10ps

module avmm_arbiter
(
    input  logic mem_master,
    input  logic rst,
    input  avmm_pkg::avmm_req_t cmd0,
    input  avmm_pkg::avmm_req_t cmd1,
    input  logic cmd_valid0,
    input  logic cmd_valid1,
    output logic grant0,
    output logic grant1,
    output avmm_pkg::avmm_req_t mem_req,
    input  avmm_pkg::avmm_rsp_t mem_rsp,
    output avmm_pkg::avmm_rsp_t rsp0,
    output avmm_pkg::avmm_rsp_t rsp1
);

    import avmm_pkg::*;

    // Port that wins if both request in the same cycle
    port_id_t rr_ptr;

    logic order_push;
    port_id_t order_port;
    logic order_pop;
    port_id_t order_head;
    logic order_not_empty;
    logic [ORDER_SPACE_W-1:0] order_space;
    logic rsp_valid;

    // Port 0 wins when it has priority or port 1 is idle, and the same for port 1
    assign grant0 = cmd_valid0 && ((rr_ptr == 1'b0) || !cmd_valid1);
    assign grant1 = cmd_valid1 && ((rr_ptr == 1'b1) || !cmd_valid0);

    assign order_push = grant0 || grant1;
    assign order_port = grant1 ? 1'b1 : 1'b0;

    // Priority moves to the port that did not win
    always_ff @(posedge mem_master)
    begin
        if (rst)
        begin
            rr_ptr <= 1'b0;
        end
        else if (order_push)
        begin
            rr_ptr <= ~order_port;
        end
    end

    // The command register toward the memory goes idle when nothing is granted
    always_ff @(posedge mem_master)
    begin
        mem_req <= grant1 ? cmd1 : cmd0;
        if (rst || !order_push)
        begin
            mem_req.read <= 1'b0;
            mem_req.write <= 1'b0;
        end
    end

    // The memory answers in order, so the oldest recorded port owns each response
    avmm_fifo
    #(
        .payload_t(port_id_t),
        .DEPTH(ORDER_DEPTH)
    )
    u_order_fifo
    (
        .mem_master(mem_master),
        .rst(rst),
        .push(order_push),
        .push_data(order_port),
        .pop(order_pop),
        .head(order_head),
        .not_empty(order_not_empty),
        .space(order_space)
    );

    assign rsp_valid = mem_rsp.readdatavalid || mem_rsp.writeresponsevalid;
    assign order_pop = rsp_valid;

    // Both ports see the payload but only the owner sees the valid flags
    always_comb
    begin
        rsp0 = mem_rsp;
        rsp1 = mem_rsp;
        if (!order_not_empty || (order_head != 1'b0))
        begin
            rsp0.readdatavalid = 1'b0;
            rsp0.writeresponsevalid = 1'b0;
        end
        if (!order_not_empty || (order_head != 1'b1))
        begin
            rsp1.readdatavalid = 1'b0;
            rsp1.writeresponsevalid = 1'b0;
        end
    end

endmodule

//--- verilog/avmm_buffer_shim.sv
// Per-port command buffering shim
`timescale 1ns/10ps

module avmm_buffer_shim
(
    input  logic mem_master,
    input  logic rst,
    input  avmm_pkg::avmm_req_t req,
    output logic waitrequest,
    output avmm_pkg::avmm_rsp_t rsp,
    output avmm_pkg::avmm_req_t cmd,
    output logic cmd_valid,
    input  logic grant,
    input  avmm_pkg::avmm_rsp_t mem_side_rsp
);

    import avmm_pkg::*;

    logic cmd_push;
    logic [CMD_SPACE_W-1:0] cmd_space;

    // A request is taken whenever the port sees waitrequest low
    assign cmd_push = (req.read || req.write) && !waitrequest;

    // Command buffer; the arbiter grant pops the head
    avmm_fifo
    #(
        .payload_t(avmm_req_t),
        .DEPTH(CMD_DEPTH)
    )
    u_cmd_fifo
    (
        .mem_master(mem_master),
        .rst(rst),
        .push(cmd_push),
        .push_data(req),
        .pop(grant),
        .head(cmd),
        .not_empty(cmd_valid),
        .space(cmd_space)
    );

    // Waitrequest works as an almost-full flag computed from last cycle's space.
    // Since the flag lags the FIFO by a cycle, requests can still land after the
    // threshold is crossed, and the CMD_ALMFULL spare entries absorb them.
    // It comes out of reset high and drops after the first clock with room.
    always_ff @(posedge mem_master)
    begin
        if (rst)
        begin
            waitrequest <= 1'b1;
        end
        else
        begin
            waitrequest <= (cmd_space <= CMD_SPACE_W'(CMD_ALMFULL));
        end
    end

    // Response stage registers whatever the arbiter steered to this port.
    // Only the valid flags are cleared by reset
    always_ff @(posedge mem_master)
    begin
        rsp <= mem_side_rsp;
        if (rst)
        begin
            rsp.readdatavalid <= 1'b0;
            rsp.writeresponsevalid <= 1'b0;
        end
    end

endmodule

//--- verilog/avmm_fifo.sv
// Synchronous FIFO with free-space count
`timescale 1ns/10ps

module avmm_fifo
#(
    parameter type payload_t = logic,
    parameter int DEPTH = 4
)
(
    input  logic mem_master,
    input  logic rst,
    input  logic push,
    input  payload_t push_data,
    input  logic pop,
    output payload_t head,
    output logic not_empty,
    output logic [$clog2(DEPTH+1)-1:0] space
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Entry storage holds payload only and needs no reset
    payload_t store [DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic do_push;
    logic do_pop;

    // Pointers wrap at DEPTH so any depth works, not just powers of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // A push into a full FIFO or a pop from an empty one is dropped
    assign do_push = push && (count != CNT_W'(DEPTH));
    assign do_pop = pop && (count != '0);

    always_ff @(posedge mem_master)
    begin
        if (do_push)
        begin
            store[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge mem_master)
    begin
        if (rst)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop)
            begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Simultaneous push and pop leave the count unchanged
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The head is read straight from storage, so a push shows up one cycle later
    assign head = store[rd_ptr];
    assign not_empty = (count != '0);
    assign space = CNT_W'(DEPTH) - count;

endmodule

//--- verilog/avmm_pkg.sv
// Avalon memory subsystem definitions

package avmm_pkg;

    // Word address and data widths seen on every port
    localparam int ADDR_W = 10;
    localparam int DATA_W = 32;
    localparam int BE_W = DATA_W / 8;

    // Implemented words; any address at or above this is out of range
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW = $clog2(MEM_WORDS);

    // Per-port command buffer depth and the almost-full threshold
    localparam int CMD_DEPTH = 8;
    localparam int CMD_ALMFULL = 2;
    localparam int CMD_SPACE_W = $clog2(CMD_DEPTH + 1);

    // Port-order tracking in the arbiter, deeper than the responses in flight
    localparam int ORDER_DEPTH = 4;
    localparam int ORDER_SPACE_W = $clog2(ORDER_DEPTH + 1);

    // Avalon response codes
    localparam logic [1:0] RSP_OKAY = 2'd0;
    localparam logic [1:0] RSP_SLVERR = 2'd2;

    // One command as presented by a requester
    typedef struct packed {
        logic read;
        logic write;
        logic [ADDR_W-1:0] address;
        logic [DATA_W-1:0] writedata;
        logic [BE_W-1:0] byteenable;
    } avmm_req_t;

    // Read and write responses, neither of them back-pressured
    typedef struct packed {
        logic readdatavalid;
        logic [DATA_W-1:0] readdata;
        logic [1:0] response;
        logic writeresponsevalid;
        logic [1:0] writeresponse;
    } avmm_rsp_t;

    // Index of the requesting port
    typedef logic [0:0] port_id_t;

endpackage
